// ==== common/fe2_params.svh ====
// Fp2 inversion engine parameters
// Field width, the Mersenne prime and the multiplier latency
`ifndef FE2_PARAMS_SVH
`define FE2_PARAMS_SVH

// Width of one base-field element
`define FE_WIDTH 31

// Mersenne prime 2^31 - 1 that the reduction relies on
`define FE_PRIME 31'h7fff_ffff

// Cycles from multiplier valid in to valid out
`define MUL_LAT 2

`endif

// ==== common/fe2_pkg.sv ====
// Fp2 inversion engine types
// Field element, multiplier tag and the two state machine encodings
`include "fe2_params.svh"

package fe2_pkg;

  // Base-field element, also one stream beat
  typedef logic [`FE_WIDTH-1:0] fe_t;

  // Which product a multiplier result belongs to
  typedef logic [1:0] mul_tag_t;

  localparam mul_tag_t TAG_A_SQ = 2'd0;
  localparam mul_tag_t TAG_B_SQ = 2'd1;
  localparam mul_tag_t TAG_RE   = 2'd2;
  localparam mul_tag_t TAG_IM   = 2'd3;

  typedef enum logic [2:0] {S_IDLE, S_SQUARE, S_NORM, S_INVERT, S_SCALE, S_HANDOFF} seq_state_t;

  typedef enum logic [1:0] {I_IDLE, I_SQR, I_MUL, I_DONE} inv_state_t;

endpackage

// ==== verilog/fp_mul.sv ====
// Modular multiplier over the prime 2^31 - 1
// Stage one registers the full product, stage two folds and corrects
// The tag travels with the data unchanged
`include "fe2_params.svh"

module fp_mul import fe2_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,
  input  fe_t      i_a,
  input  fe_t      i_b,
  input  mul_tag_t i_tag,
  output logic     o_val,
  output fe_t      o_res,
  output mul_tag_t o_tag
);

  logic [2*`FE_WIDTH-1:0] prod_q;
  logic                   val_q;
  mul_tag_t               tag_q;
  logic [`FE_WIDTH:0]     fold;
  logic [`FE_WIDTH:0]     fold_sub;

  // 2^31 is 1 mod P, so the high half adds onto the low half
  assign fold     = {1'b0, prod_q[`FE_WIDTH-1:0]} + {1'b0, prod_q[2*`FE_WIDTH-1:`FE_WIDTH]};
  assign fold_sub = fold - {1'b0, `FE_PRIME};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= 1'b0;
      o_val <= 1'b0;
    end else begin
      val_q <= i_val;
      o_val <= val_q;
    end
  end

  always_ff @(posedge i_clk) begin
    prod_q <= {{`FE_WIDTH{1'b0}}, i_a} * {{`FE_WIDTH{1'b0}}, i_b};
    tag_q  <= i_tag;
    o_tag  <= tag_q;
    // One subtract is enough since the fold stays below 2P
    o_res  <= (fold >= {1'b0, `FE_PRIME}) ? fold_sub[`FE_WIDTH-1:0] : fold[`FE_WIDTH-1:0];
  end

  // Folded result equals the full product reduced mod P
  a_res_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (64'(o_res) == 64'($past(prod_q)) % 64'(`FE_PRIME)));

endmodule

// ==== verilog/fp_addsub.sv ====
// Modular adder and subtractor over the prime 2^31 - 1
// Result is corrected into [0, P) and registered
`include "fe2_params.svh"

module fp_addsub import fe2_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  input  logic i_sub,
  input  fe_t  i_a,
  input  fe_t  i_b,
  output logic o_val,
  output fe_t  o_res
);

  logic [`FE_WIDTH:0] sum;
  logic [`FE_WIDTH:0] diff;
  logic [`FE_WIDTH:0] res_n;

  assign sum  = {1'b0, i_a} + {1'b0, i_b};
  assign diff = {1'b0, i_a} - {1'b0, i_b};

  always_comb begin
    if (i_sub) begin
      // Borrow into the top bit means a < b
      res_n = diff[`FE_WIDTH] ? diff + {1'b0, `FE_PRIME} : diff;
    end else begin
      res_n = (sum >= {1'b0, `FE_PRIME}) ? sum - {1'b0, `FE_PRIME} : sum;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else begin
      o_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    o_res <= res_n[`FE_WIDTH-1:0];
  end

  a_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> (i_a < `FE_PRIME) && (i_b < `FE_PRIME));

endmodule

// ==== fp_inv/fp_inv.sv ====
// Base-field inverter by Fermat exponentiation, x^(P-2) mod P
// Left to right square and multiply over the exponent bits
// Uses a private multiplier and gives 0 for input 0
`include "fe2_params.svh"

module fp_inv import fe2_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  input  fe_t  i_dat,
  output logic o_val,
  output fe_t  o_res
);

  localparam fe_t      EXP     = fe_t'(`FE_PRIME - 2);
  localparam mul_tag_t TAG_SQR = 2'd0;
  localparam mul_tag_t TAG_MUL = 2'd1;

  inv_state_t state;
  fe_t        base;
  fe_t        acc;
  logic [4:0] bit_idx;
  logic       mul_val;
  fe_t        mul_a;
  fe_t        mul_b;
  mul_tag_t   mul_tag;
  logic       mul_o_val;
  fe_t        mul_res;
  mul_tag_t   mul_o_tag;

  fp_mul u_mul (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (mul_val),
    .i_a   (mul_a),
    .i_b   (mul_b),
    .i_tag (mul_tag),
    .o_val (mul_o_val),
    .o_res (mul_res),
    .o_tag (mul_o_tag)
  );

  assign o_val = (state == I_DONE);
  assign o_res = acc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= I_IDLE;
      mul_val <= 1'b0;
      bit_idx <= '0;
    end else begin
      mul_val <= 1'b0;
      case (state)
        I_IDLE: begin
          if (i_val) begin
            // Top exponent bit is set, so the accumulator starts at the base
            base    <= i_dat;
            acc     <= i_dat;
            bit_idx <= 5'd29;
            mul_val <= 1'b1;
            mul_a   <= i_dat;
            mul_b   <= i_dat;
            mul_tag <= TAG_SQR;
            state   <= I_SQR;
          end
        end
        I_SQR: begin
          if (mul_o_val && mul_o_tag == TAG_SQR) begin
            acc <= mul_res;
            if (EXP[bit_idx]) begin
              mul_val <= 1'b1;
              mul_a   <= mul_res;
              mul_b   <= base;
              mul_tag <= TAG_MUL;
              state   <= I_MUL;
            end else if (bit_idx == '0) begin
              state <= I_DONE;
            end else begin
              bit_idx <= bit_idx - 5'd1;
              mul_val <= 1'b1;
              mul_a   <= mul_res;
              mul_b   <= mul_res;
              mul_tag <= TAG_SQR;
            end
          end
        end
        I_MUL: begin
          if (mul_o_val && mul_o_tag == TAG_MUL) begin
            acc <= mul_res;
            if (bit_idx == '0) begin
              state <= I_DONE;
            end else begin
              bit_idx <= bit_idx - 5'd1;
              mul_val <= 1'b1;
              mul_a   <= mul_res;
              mul_b   <= mul_res;
              mul_tag <= TAG_SQR;
              state   <= I_SQR;
            end
          end
        end
        default: state <= I_IDLE;
      endcase
    end
  end

  a_no_overlap: assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> (state == I_IDLE));

endmodule

// ==== fe2_inv/fe2_inv_seq.sv ====
// Fp2 inversion sequencer
// Issues a^2, b^2, their sum, the base-field inverse, 0 - b
// and the two final products to the shared arithmetic units
// Result is (a - b*u) / (a^2 + b^2)
`include "fe2_params.svh"

module fe2_inv_seq import fe2_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_start,
  input  fe_t      i_a,
  input  fe_t      i_b,
  output logic     o_busy,
  output logic     o_mul_val,
  output fe_t      o_mul_a,
  output fe_t      o_mul_b,
  output mul_tag_t o_mul_tag,
  input  logic     i_mul_val,
  input  fe_t      i_mul_res,
  input  mul_tag_t i_mul_tag,
  output logic     o_as_val,
  output logic     o_as_sub,
  output fe_t      o_as_a,
  output fe_t      o_as_b,
  input  logic     i_as_val,
  input  fe_t      i_as_res,
  output logic     o_inv_val,
  output fe_t      o_inv_dat,
  input  logic     i_inv_val,
  input  fe_t      i_inv_res,
  output logic     o_res_val,
  output fe_t      o_res_re,
  output fe_t      o_res_im,
  input  logic     i_done
);

  seq_state_t state;
  logic       second;
  fe_t        a_q;
  fe_t        b_q;
  fe_t        a_sq;
  fe_t        neg_b;
  fe_t        inv_q;
  fe_t        re_q;

  assign o_busy    = (state != S_IDLE);
  assign o_res_val = (state == S_SCALE) && i_mul_val && (i_mul_tag == TAG_IM);
  assign o_res_re  = re_q;
  assign o_res_im  = i_mul_res;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      second    <= 1'b0;
      o_mul_val <= 1'b0;
      o_as_val  <= 1'b0;
      o_inv_val <= 1'b0;
    end else begin
      o_mul_val <= 1'b0;
      o_as_val  <= 1'b0;
      o_inv_val <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            a_q       <= i_a;
            b_q       <= i_b;
            o_mul_val <= 1'b1;
            o_mul_a   <= i_a;
            o_mul_b   <= i_a;
            o_mul_tag <= TAG_A_SQ;
            second    <= 1'b1;
            state     <= S_SQUARE;
          end
        end
        S_SQUARE: begin
          if (second) begin
            o_mul_val <= 1'b1;
            o_mul_a   <= b_q;
            o_mul_b   <= b_q;
            o_mul_tag <= TAG_B_SQ;
            second    <= 1'b0;
          end
          if (i_mul_val && i_mul_tag == TAG_A_SQ) begin
            a_sq <= i_mul_res;
          end
          // a^2 returned the cycle before
          if (i_mul_val && i_mul_tag == TAG_B_SQ) begin
            o_as_val <= 1'b1;
            o_as_sub <= 1'b0;
            o_as_a   <= a_sq;
            o_as_b   <= i_mul_res;
            state    <= S_NORM;
          end
        end
        S_NORM: begin
          if (i_as_val) begin
            o_inv_val <= 1'b1;
            o_inv_dat <= i_as_res;
            // Negate b while the inverter runs
            o_as_val  <= 1'b1;
            o_as_sub  <= 1'b1;
            o_as_a    <= '0;
            o_as_b    <= b_q;
            state     <= S_INVERT;
          end
        end
        S_INVERT: begin
          if (i_as_val) begin
            neg_b <= i_as_res;
          end
          if (i_inv_val) begin
            inv_q     <= i_inv_res;
            o_mul_val <= 1'b1;
            o_mul_a   <= a_q;
            o_mul_b   <= i_inv_res;
            o_mul_tag <= TAG_RE;
            second    <= 1'b1;
            state     <= S_SCALE;
          end
        end
        S_SCALE: begin
          if (second) begin
            o_mul_val <= 1'b1;
            o_mul_a   <= neg_b;
            o_mul_b   <= inv_q;
            o_mul_tag <= TAG_IM;
            second    <= 1'b0;
          end
          if (i_mul_val && i_mul_tag == TAG_RE) begin
            re_q <= i_mul_res;
          end
          if (o_res_val) begin
            state <= S_HANDOFF;
          end
        end
        S_HANDOFF: begin
          if (i_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
    i_start |-> !o_busy);

  // Each product comes back after the fixed latency with its own tag
  a_mul_return: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mul_val |-> ##`MUL_LAT (i_mul_val && i_mul_tag == $past(o_mul_tag, `MUL_LAT)));

endmodule

// ==== verilog/fe2_stream_in.sv ====
// Input side of the Fp2 inverter
// Collects the c0 and c1 beats and starts the sequencer
// Holds ready low while an inversion is in progress
module fe2_stream_in import fe2_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  input  logic i_sop,
  input  logic i_eop,
  input  fe_t  i_dat,
  output logic o_rdy,
  input  logic i_busy,
  output logic o_start,
  output fe_t  o_a,
  output fe_t  o_b
);

  logic have_a;

  // Start pulse covers the cycle before busy rises
  assign o_rdy = ~(i_busy | o_start);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      have_a  <= 1'b0;
      o_start <= 1'b0;
    end else begin
      o_start <= 1'b0;
      if (i_val && o_rdy) begin
        if (i_sop) begin
          have_a <= 1'b1;
          o_a    <= i_dat;
        end else if (have_a && i_eop) begin
          have_a  <= 1'b0;
          o_b     <= i_dat;
          o_start <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/fe2_stream_out.sv ====
// Output side of the Fp2 inverter
// Holds the result and sends real then imaginary part
// Each beat waits for ready, done pulses after the eop transfer
module fe2_stream_out import fe2_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_res_val,
  input  fe_t  i_re,
  input  fe_t  i_im,
  output logic o_val,
  output logic o_sop,
  output logic o_eop,
  output fe_t  o_dat,
  input  logic i_rdy,
  output logic o_done
);

  fe_t  re_q;
  fe_t  im_q;
  logic beat;

  assign o_sop = ~beat;
  assign o_eop = beat;
  assign o_dat = beat ? im_q : re_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val  <= 1'b0;
      beat   <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_res_val) begin
        o_val <= 1'b1;
        beat  <= 1'b0;
      end else if (o_val && i_rdy) begin
        if (beat) begin
          o_val  <= 1'b0;
          beat   <= 1'b0;
          o_done <= 1'b1;
        end else begin
          beat <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_res_val) begin
      re_q <= i_re;
      im_q <= i_im;
    end
  end

endmodule

// ==== verilog/fe2_inv_top.sv ====
// Fp2 inversion engine over Fp[u]/(u^2 + 1), P = 2^31 - 1
// Stream in a + b*u as two beats, stream out its inverse the same way
module fe2_inv_top import fe2_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  output logic o_rdy,
  input  logic i_sop,
  input  logic i_eop,
  input  fe_t  i_dat,
  output logic o_val,
  input  logic i_rdy,
  output logic o_sop,
  output logic o_eop,
  output fe_t  o_dat
);

  logic     start, busy, done;
  fe_t      in_a, in_b;
  logic     mul_val, mul_o_val;
  fe_t      mul_a, mul_b, mul_res;
  mul_tag_t mul_tag, mul_o_tag;
  logic     as_val, as_sub, as_o_val;
  fe_t      as_a, as_b, as_res;
  logic     inv_val, inv_o_val;
  fe_t      inv_dat, inv_res;
  logic     res_val;
  fe_t      res_re, res_im;

  fe2_stream_in u_in (
    .i_clk (i_clk), .i_rst (i_rst), .i_val (i_val), .i_sop (i_sop), .i_eop (i_eop),
    .i_dat (i_dat), .o_rdy (o_rdy), .i_busy (busy), .o_start (start),
    .o_a (in_a), .o_b (in_b)
  );

  fe2_inv_seq u_seq (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (start), .i_a (in_a), .i_b (in_b),
    .o_busy (busy),
    .o_mul_val (mul_val), .o_mul_a (mul_a), .o_mul_b (mul_b), .o_mul_tag (mul_tag),
    .i_mul_val (mul_o_val), .i_mul_res (mul_res), .i_mul_tag (mul_o_tag),
    .o_as_val (as_val), .o_as_sub (as_sub), .o_as_a (as_a), .o_as_b (as_b),
    .i_as_val (as_o_val), .i_as_res (as_res),
    .o_inv_val (inv_val), .o_inv_dat (inv_dat), .i_inv_val (inv_o_val), .i_inv_res (inv_res),
    .o_res_val (res_val), .o_res_re (res_re), .o_res_im (res_im), .i_done (done)
  );

  fp_mul u_mul (
    .i_clk (i_clk), .i_rst (i_rst), .i_val (mul_val), .i_a (mul_a), .i_b (mul_b),
    .i_tag (mul_tag), .o_val (mul_o_val), .o_res (mul_res), .o_tag (mul_o_tag)
  );

  fp_addsub u_as (
    .i_clk (i_clk), .i_rst (i_rst), .i_val (as_val), .i_sub (as_sub), .i_a (as_a),
    .i_b (as_b), .o_val (as_o_val), .o_res (as_res)
  );

  fp_inv u_inv (
    .i_clk (i_clk), .i_rst (i_rst), .i_val (inv_val), .i_dat (inv_dat),
    .o_val (inv_o_val), .o_res (inv_res)
  );

  fe2_stream_out u_out (
    .i_clk (i_clk), .i_rst (i_rst), .i_res_val (res_val), .i_re (res_re), .i_im (res_im),
    .o_val (o_val), .o_sop (o_sop), .o_eop (o_eop), .o_dat (o_dat), .i_rdy (i_rdy),
    .o_done (done)
  );

endmodule

// ==== tests/tb_fe2_inv.sv ====
// Testbench for the Fp2 inversion engine
// Random and edge elements are checked against a model of
// (a - b*u) / (a^2 + b^2) mod 2^31 - 1, with and without output back-pressure
`include "fe2_params.svh"

module tb_fe2_inv import fe2_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [63:0] P       = 64'(`FE_PRIME);
  localparam int          SEED    = 65679;
  localparam int          TIMEOUT = 2000;

  logic i_clk, i_rst, i_val, i_sop, i_eop, i_rdy;
  fe_t  i_dat;
  logic o_rdy, o_val, o_sop, o_eop;
  fe_t  o_dat;
  int unsigned seed_ret;

  fe2_inv_top i_dut (
    .i_clk (i_clk), .i_rst (i_rst), .i_val (i_val), .o_rdy (o_rdy), .i_sop (i_sop),
    .i_eop (i_eop), .i_dat (i_dat), .o_val (o_val), .i_rdy (i_rdy), .o_sop (o_sop),
    .o_eop (o_eop), .o_dat (o_dat)
  );

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "wait timed out");
  endtask

  function automatic logic [63:0] mod_mul(input logic [63:0] x, input logic [63:0] y);
    return (x * y) % P;
  endfunction

  // Square and multiply from the low exponent bit up
  function automatic logic [63:0] pow_mod(input logic [63:0] base, input logic [63:0] e);
    logic [63:0] r;
    logic [63:0] b;
    logic [63:0] k;
    r = 64'd1;
    b = base % P;
    k = e;
    while (k != 0) begin
      if (k[0]) r = mod_mul(r, b);
      b = mod_mul(b, b);
      k = k >> 1;
    end
    return r;
  endfunction

  task automatic send_beat(input logic [63:0] dat, input logic sop, input logic eop);
    int cnt;
    cnt = 0;
    @(posedge i_clk);
    i_val <= 1'b1;
    i_sop <= sop;
    i_eop <= eop;
    i_dat <= fe_t'(dat);
    @(negedge i_clk);
    while (!o_rdy) begin
      cnt++;
      if (cnt > TIMEOUT) timeout_abort("input ready");
      @(negedge i_clk);
    end
    // Beat is taken on this edge
    @(posedge i_clk);
    i_val <= 1'b0;
    i_sop <= 1'b0;
    i_eop <= 1'b0;
  endtask

  task automatic collect_result(input logic [63:0] exp_re, input logic [63:0] exp_im,
                                input logic bp);
    int   beats;
    int   cnt;
    int   stall;
    logic hold;
    logic hold_sop;
    logic hold_eop;
    fe_t  hold_dat;
    beats = 0;
    cnt   = 0;
    stall = 0;
    hold  = 1'b0;
    while (beats < 2) begin
      @(posedge i_clk);
      if (bp && stall > 0) begin
        i_rdy <= 1'b0;
        stall--;
      end else begin
        i_rdy <= 1'b1;
        if (bp && $urandom_range(2, 0) == 0) stall = $urandom_range(6, 1);
      end
      @(negedge i_clk);
      cnt++;
      if (cnt > TIMEOUT) timeout_abort("output beats");
      check_value("input ready while busy", 64'(o_rdy), 64'd0);
      if (hold) begin
        // Beat not taken yet must not change
        check_value("valid held", 64'(o_val), 64'd1);
        check_value("data held", 64'(o_dat), 64'(hold_dat));
        check_value("sop held", 64'(o_sop), 64'(hold_sop));
        check_value("eop held", 64'(o_eop), 64'(hold_eop));
      end
      hold = 1'b0;
      if (o_val && i_rdy) begin
        check_value("sop flag", 64'(o_sop), (beats == 0) ? 64'd1 : 64'd0);
        check_value("eop flag", 64'(o_eop), (beats == 0) ? 64'd0 : 64'd1);
        check_value((beats == 0) ? "real part" : "imaginary part", 64'(o_dat),
                    (beats == 0) ? exp_re : exp_im);
        beats++;
      end else if (o_val) begin
        hold     = 1'b1;
        hold_sop = o_sop;
        hold_eop = o_eop;
        hold_dat = o_dat;
      end
    end
    @(posedge i_clk);
    @(negedge i_clk);
    check_value("valid after eop", 64'(o_val), 64'd0);
  endtask

  task automatic run_element(input logic [63:0] a, input logic [63:0] b, input logic bp);
    logic [63:0] inv;
    logic [63:0] re;
    logic [63:0] im;
    inv = pow_mod((mod_mul(a, a) + mod_mul(b, b)) % P, P - 64'd2);
    re  = mod_mul(a, inv);
    im  = mod_mul((P - b) % P, inv);
    // (a + b*u) times the model result gives one
    if (a != 0 || b != 0) begin
      check_value("model real product", (mod_mul(a, re) + P - mod_mul(b, im)) % P, 64'd1);
      check_value("model imaginary product", (mod_mul(a, im) + mod_mul(b, re)) % P, 64'd0);
    end
    send_beat(a, 1'b1, 1'b0);
    repeat ($urandom_range(2, 0)) @(posedge i_clk);
    send_beat(b, 1'b0, 1'b1);
    collect_result(re, im, bp);
  endtask

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    i_rst = 1'b1;
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
    i_dat = '0;
    i_rdy = 1'b0;
    seed_ret = $urandom(SEED);
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    check_value("valid after reset", 64'(o_val), 64'd0);
    check_value("ready after reset", 64'(o_rdy), 64'd1);
    run_element(64'd0, 64'd0, 1'b0);
    run_element(64'd1, 64'd0, 1'b1);
    run_element(64'd0, 64'd1, 1'b0);
    run_element(P - 64'd1, P - 64'd1, 1'b1);
    for (int i = 0; i < 200; i++) begin
      a = 64'($urandom) % P;
      b = (i % 25 == 0) ? 64'd0 : 64'($urandom) % P;
      run_element(a, b, i[0]);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== fe2_inv.f ====
+incdir+common
common/fe2_pkg.sv
verilog/fp_mul.sv
verilog/fp_addsub.sv
fp_inv/fp_inv.sv
fe2_inv/fe2_inv_seq.sv
verilog/fe2_stream_in.sv
verilog/fe2_stream_out.sv
verilog/fe2_inv_top.sv
tests/tb_fe2_inv.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the Fp2 inversion testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f fe2_inv.f --top-module tb_fe2_inv -o tb_fe2_inv
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_fe2_inv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
